// File: rtl/pito_pkg.sv
`default_nettype none

package pito_pkg;

    // ==================================================================
    // sizes
    // ==================================================================
    localparam int xlen = 32;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] word_t;
    typedef logic [31:0]     instr_t;
    typedef logic [31:0]     pc_t;

    // hart count bound, structs carry a hart field this wide
    localparam int max_harts = 8;
    typedef logic [$clog2(max_harts)-1:0] hart_t;

    // fetch to commit in cycles, harts must outnumber it
    localparam int pipe_depth = 4;

    // each hart owns 64 code words, base = hart * 256 bytes
    localparam int hart_span_words = 64;
    localparam int imem_words      = max_harts * hart_span_words;
    typedef logic [$clog2(imem_words)-1:0] imem_addr_t;

    localparam int dmem_words = 256;
    typedef logic [$clog2(dmem_words)-1:0] dmem_addr_t;

    // ==================================================================
    // encodings
    // ==================================================================
    typedef enum logic [3:0] {
        op_nop, op_add, op_sub, op_and, op_or, op_xor, op_addi,
        op_lui, op_lw, op_sw, op_beq, op_bne, op_jal
    } op_e;

    // rv32 major opcodes
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;

    // funct3 / funct7
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_word    = 3'b010;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;
    localparam logic [6:0] f7_base    = 7'b0000000;
    localparam logic [6:0] f7_sub     = 7'b0100000;

    // ==================================================================
    // stage structs
    // ==================================================================
    typedef struct packed {
        logic      valid;
        hart_t     hart;
        op_e       op;
        reg_addr_t rd;
        word_t     rs1;
        word_t     rs2;
        word_t     imm;
        pc_t       pc;
    } dec_t;

    typedef struct packed {
        logic      valid;
        hart_t     hart;
        op_e       op;
        reg_addr_t rd;
        word_t     result;
        word_t     store_data;
        word_t     addr;
    } ex_t;

    typedef struct packed {
        logic  valid;
        hart_t hart;
        pc_t   pc;
    } redirect_t;

    typedef struct packed {
        logic      valid;
        hart_t     hart;
        reg_addr_t rd;
        word_t     data;
    } commit_t;

endpackage

`default_nettype wire

// File: rtl/pito_hart_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module pito_hart_ctrl import pito_pkg::*; #(
    parameter  int num_harts = 8,
    localparam int hart_w    = $clog2(num_harts)
) (
    input  wire logic              clk,
    input  wire logic              pito_io_rst_n,
    input  wire redirect_t         redirect,
    output pc_t                    fetch_pc,
    output logic [hart_w-1:0]      fetch_hart,
    output logic                   fetch_valid
);

    // a hart must retire before it issues again
    if (num_harts < pipe_depth + 1 || num_harts > max_harts) begin : g_bad_cfg
        $error("pito_hart_ctrl: num_harts out of range");
    end

    // ==================================================================
    // round robin hart counter
    // ==================================================================
    logic [hart_w-1:0] hart_cnt;
    logic              run_q;
    pc_t               pc_q [num_harts];

    // run_q holds the counter at 0 for the first cycle out of reset
    always_ff @(posedge clk) begin
        if (!pito_io_rst_n) begin
            hart_cnt <= '0;
            run_q    <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (run_q) begin
                // wrap on non power of two counts too
                if (hart_cnt == hart_w'(num_harts - 1)) begin
                    hart_cnt <= '0;
                end else begin
                    hart_cnt <= hart_cnt + 1'b1;
                end
            end
        end
    end

    // ==================================================================
    // per-hart program counters
    // ==================================================================
    // redirect always carries the full next pc of its hart
    always_ff @(posedge clk) begin
        if (!pito_io_rst_n) begin
            for (int h = 0; h < num_harts; h++) begin
                pc_q[h] <= pc_t'(h * hart_span_words * 4);
            end
        end else if (redirect.valid) begin
            pc_q[redirect.hart[hart_w-1:0]] <= redirect.pc;
        end
    end

    // fetch address of the hart in its slot
    assign fetch_pc    = pc_q[hart_cnt];
    assign fetch_hart  = hart_cnt;
    assign fetch_valid = run_q;

endmodule

`default_nettype wire

// File: rtl/pito_imem.sv
`timescale 1ns/10ps
`default_nettype none

module pito_imem import pito_pkg::*; (
    input  wire logic       clk,
    input  wire logic       we,
    input  wire imem_addr_t waddr,
    input  wire instr_t     wdata,
    input  wire imem_addr_t raddr,
    output instr_t          rdata
);

    // shared code store, one region per hart
    instr_t mem [imem_words];

    // io write port, loaded during reset
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, word one cycle after the address
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// File: rtl/pito_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module pito_decoder import pito_pkg::*; #(
    parameter  int num_harts = 8,
    localparam int hart_w    = $clog2(num_harts)
) (
    input  wire logic              clk,
    input  wire logic              pito_io_rst_n,
    input  wire instr_t            instr,
    input  wire pc_t               fetch_pc,
    input  wire logic [hart_w-1:0] fetch_hart,
    input  wire logic              fetch_valid,
    output reg_addr_t              rs1_addr,
    output reg_addr_t              rs2_addr,
    input  wire word_t             rs1_val,
    input  wire word_t             rs2_val,
    output dec_t                   dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    op_e        op;
    word_t      imm;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // register file read addresses straight from the word
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    // ==================================================================
    // operation match
    // ==================================================================
    // anything unmatched stays op_nop
    always_comb begin
        op = op_nop;
        case (opcode)
            opc_op: begin
                if (funct7 == f7_base) begin
                    case (funct3)
                        f3_add_sub: op = op_add;
                        f3_xor:     op = op_xor;
                        f3_or:      op = op_or;
                        f3_and:     op = op_and;
                        default:    op = op_nop;
                    endcase
                end else if (funct7 == f7_sub && funct3 == f3_add_sub) begin
                    op = op_sub;
                end
            end
            opc_op_imm: if (funct3 == f3_add_sub) op = op_addi;
            opc_lui:    op = op_lui;
            opc_load:   if (funct3 == f3_word) op = op_lw;
            opc_store:  if (funct3 == f3_word) op = op_sw;
            opc_branch: begin
                if (funct3 == f3_beq) op = op_beq;
                else if (funct3 == f3_bne) op = op_bne;
            end
            opc_jal:    op = op_jal;
            default:    op = op_nop;
        endcase
    end

    // immediate by format, i type by default
    always_comb begin
        case (op)
            op_sw:         imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            op_beq, op_bne: imm = {{19{instr[31]}}, instr[31], instr[7],
                                   instr[30:25], instr[11:8], 1'b0};
            op_lui:        imm = {instr[31:12], 12'b0};
            op_jal:        imm = {{11{instr[31]}}, instr[31], instr[19:12],
                                  instr[20], instr[30:21], 1'b0};
            default:       imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    // ==================================================================
    // decode register
    // ==================================================================
    always_ff @(posedge clk) begin
        if (!pito_io_rst_n) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= fetch_valid;
        end
        dec.hart <= hart_t'(fetch_hart);
        dec.op   <= op;
        dec.rd   <= instr[11:7];
        dec.rs1  <= rs1_val;
        dec.rs2  <= rs2_val;
        dec.imm  <= imm;
        dec.pc   <= fetch_pc;
    end

endmodule

`default_nettype wire

// File: rtl/pito_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module pito_regfile import pito_pkg::*; #(
    parameter  int num_harts = 8,
    localparam int hart_w    = $clog2(num_harts)
) (
    input  wire logic              clk,
    input  wire logic [hart_w-1:0] rd_hart,
    input  wire reg_addr_t         rs1_addr,
    input  wire reg_addr_t         rs2_addr,
    output word_t                  rs1_val,
    output word_t                  rs2_val,
    input  wire commit_t           wr
);

    // one bank of 32 per hart
    word_t regs [num_harts][32];

    // x0 never written
    always_ff @(posedge clk) begin
        if (wr.valid && wr.rd != '0) begin
            regs[wr.hart[hart_w-1:0]][wr.rd] <= wr.data;
        end
    end

    // two async read ports in the decoding hart's bank, x0 reads zero
    assign rs1_val = (rs1_addr == '0) ? '0 : regs[rd_hart][rs1_addr];
    assign rs2_val = (rs2_addr == '0) ? '0 : regs[rd_hart][rs2_addr];

endmodule

`default_nettype wire

// File: rtl/pito_execute.sv
`timescale 1ns/10ps
`default_nettype none

module pito_execute import pito_pkg::*; #(
    parameter  int num_harts = 8,
    localparam int hart_w    = $clog2(num_harts)
) (
    input  wire logic   clk,
    input  wire logic   pito_io_rst_n,
    input  wire dec_t   dec,
    output ex_t         ex,
    output redirect_t   redirect
);

    word_t result;
    word_t addr;
    logic  taken;
    pc_t   pc_plus4;
    pc_t   next_pc;

    // ==================================================================
    // alu
    // ==================================================================
    always_comb begin
        case (dec.op)
            op_add:  result = dec.rs1 + dec.rs2;
            op_sub:  result = dec.rs1 - dec.rs2;
            op_and:  result = dec.rs1 & dec.rs2;
            op_or:   result = dec.rs1 | dec.rs2;
            op_xor:  result = dec.rs1 ^ dec.rs2;
            op_addi: result = dec.rs1 + dec.imm;
            op_lui:  result = dec.imm;
            // link value
            op_jal:  result = pc_plus4;
            default: result = '0;
        endcase
    end

    // effective address for lw and sw
    assign addr = dec.rs1 + dec.imm;

    // ==================================================================
    // branch and next pc
    // ==================================================================
    assign pc_plus4 = dec.pc + 32'd4;
    assign taken    = (dec.op == op_beq && dec.rs1 == dec.rs2) ||
                      (dec.op == op_bne && dec.rs1 != dec.rs2);

    // nops also step the pc
    assign next_pc = (taken || dec.op == op_jal) ? dec.pc + dec.imm : pc_plus4;

    // same cycle back to the pc table, hart trimmed to configured count
    assign redirect.valid = dec.valid;
    assign redirect.hart  = hart_t'(dec.hart[hart_w-1:0]);
    assign redirect.pc    = next_pc;

    // execute register
    always_ff @(posedge clk) begin
        if (!pito_io_rst_n) begin
            ex.valid <= 1'b0;
        end else begin
            ex.valid <= dec.valid;
        end
        ex.hart       <= dec.hart;
        ex.op         <= dec.op;
        ex.rd         <= dec.rd;
        ex.result     <= result;
        ex.store_data <= dec.rs2;
        ex.addr       <= addr;
    end

endmodule

`default_nettype wire

// File: rtl/pito_mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module pito_mem_stage import pito_pkg::*; (
    input  wire logic       clk,
    input  wire logic       pito_io_rst_n,
    input  wire ex_t        ex,
    input  wire logic       prog_en,
    input  wire logic       dmem_we,
    input  wire dmem_addr_t dmem_addr,
    input  wire word_t      dmem_data,
    output commit_t         commit
);

    localparam int dmem_aw = $bits(dmem_addr_t);

    word_t      mem [dmem_words];
    dmem_addr_t core_addr;
    logic       mem_we;
    dmem_addr_t mem_waddr;
    word_t      mem_wdata;
    word_t      load_word;
    logic       writes_rd;

    // byte address to word index, wraps over the memory
    assign core_addr = ex.addr[dmem_aw+1:2];

    // ==================================================================
    // data memory
    // ==================================================================
    // program mode hands the write port to io, core sw dropped
    assign mem_we    = prog_en ? dmem_we : (ex.valid && ex.op == op_sw);
    assign mem_waddr = prog_en ? dmem_addr : core_addr;
    assign mem_wdata = prog_en ? dmem_data : ex.store_data;

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_waddr] <= mem_wdata;
        end
    end

    assign load_word = mem[core_addr];

    // ==================================================================
    // register write stage
    // ==================================================================
    assign writes_rd = ex.op inside {op_add, op_sub, op_and, op_or, op_xor,
                                     op_addi, op_lui, op_lw, op_jal};

    always_ff @(posedge clk) begin
        if (!pito_io_rst_n) begin
            commit.valid <= 1'b0;
        end else begin
            commit.valid <= ex.valid && writes_rd;
        end
        commit.hart <= ex.hart;
        commit.rd   <= ex.rd;
        // x0 reports zero
        if (ex.rd == '0) begin
            commit.data <= '0;
        end else begin
            commit.data <= (ex.op == op_lw) ? load_word : ex.result;
        end
    end

endmodule

`default_nettype wire

// File: rtl/pito_core.sv
`timescale 1ns/10ps
`default_nettype none

module pito_core import pito_pkg::*; #(
    parameter  int num_harts = 8,
    localparam int hart_w    = $clog2(num_harts)
) (
    input  wire logic       clk,
    input  wire logic       pito_io_rst_n,
    input  wire logic       imem_we,
    input  wire imem_addr_t imem_addr,
    input  wire instr_t     imem_data,
    input  wire logic       prog_en,
    input  wire logic       dmem_we,
    input  wire dmem_addr_t dmem_addr,
    input  wire word_t      dmem_data,
    output commit_t         commit
);

    // ==================================================================
    // fetch
    // ==================================================================
    pc_t               fetch_pc;
    logic [hart_w-1:0] fetch_hart;
    logic              fetch_valid;
    redirect_t         redirect;
    instr_t            instr;

    pito_hart_ctrl #(.num_harts(num_harts)) i_hart_ctrl (
        .clk          (clk),
        .pito_io_rst_n(pito_io_rst_n),
        .redirect     (redirect),
        .fetch_pc     (fetch_pc),
        .fetch_hart   (fetch_hart),
        .fetch_valid  (fetch_valid)
    );

    pito_imem i_imem (
        .clk  (clk),
        .we   (imem_we),
        .waddr(imem_addr),
        .wdata(imem_data),
        .raddr(fetch_pc[$bits(imem_addr_t)+1:2]),
        .rdata(instr)
    );

    // pc, hart and valid follow the word out of imem
    pc_t               f1_pc;
    logic [hart_w-1:0] f1_hart;
    logic              f1_valid;

    always_ff @(posedge clk) begin
        if (!pito_io_rst_n) begin
            f1_valid <= 1'b0;
        end else begin
            f1_valid <= fetch_valid;
        end
        f1_pc   <= fetch_pc;
        f1_hart <= fetch_hart;
    end

    // ==================================================================
    // decode, execute, memory
    // ==================================================================
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_val;
    word_t     rs2_val;
    dec_t      dec;
    ex_t       ex;

    pito_decoder #(.num_harts(num_harts)) i_decoder (
        .clk          (clk),
        .pito_io_rst_n(pito_io_rst_n),
        .instr        (instr),
        .fetch_pc     (f1_pc),
        .fetch_hart   (f1_hart),
        .fetch_valid  (f1_valid),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .dec          (dec)
    );

    // written back from the commit trace
    pito_regfile #(.num_harts(num_harts)) i_regfile (
        .clk     (clk),
        .rd_hart (f1_hart),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .wr      (commit)
    );

    pito_execute #(.num_harts(num_harts)) i_execute (
        .clk          (clk),
        .pito_io_rst_n(pito_io_rst_n),
        .dec          (dec),
        .ex           (ex),
        .redirect     (redirect)
    );

    pito_mem_stage i_mem_stage (
        .clk          (clk),
        .pito_io_rst_n(pito_io_rst_n),
        .ex           (ex),
        .prog_en      (prog_en),
        .dmem_we      (dmem_we),
        .dmem_addr    (dmem_addr),
        .dmem_data    (dmem_data),
        .commit       (commit)
    );

endmodule

`default_nettype wire

// File: testbench/pito_core_props.sv
`timescale 1ns/10ps
`default_nettype none

module pito_core_props import pito_pkg::*; #(
    parameter int num_harts = 8
) (
    input wire logic    clk,
    input wire logic    pito_io_rst_n,
    input wire commit_t commit
);

    // pipeline still empty for fetch to commit after release
    assert property (@(posedge clk) $rose(pito_io_rst_n) |-> !commit.valid [*5])
        else $error("commit valid too early after reset");

    // ==================================================================
    // round robin spacing
    // ==================================================================
    for (genvar k = 1; k < num_harts; k++) begin : g_spacing
        assert property (@(posedge clk) disable iff (!pito_io_rst_n)
            commit.valid && $past(commit.valid, k) |-> commit.hart != $past(commit.hart, k))
            else $error("hart repeated within %0d cycles", k);
    end

    // x0 writes report zero
    assert property (@(posedge clk) disable iff (!pito_io_rst_n)
        commit.valid && commit.rd == '0 |-> commit.data == '0)
        else $error("commit to x0 with nonzero data");

endmodule

bind pito_core pito_core_props #(.num_harts(num_harts)) i_props (
    .clk          (clk),
    .pito_io_rst_n(pito_io_rst_n),
    .commit       (commit)
);

`default_nettype wire

// File: testbench/pito_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module pito_core_tb import pito_pkg::*; ();

    localparam int num_harts = 8;
    localparam int prog_len  = 21;
    // two runs of the longest program, plus loading and margin
    localparam int run_ns     = num_harts * 4 * prog_len * 20;
    localparam int timeout_ns = 2 * run_ns + 300 * 20 + 5000;

    logic       clk;
    logic       pito_io_rst_n;
    logic       imem_we;
    imem_addr_t imem_addr;
    instr_t     imem_data;
    logic       prog_en;
    logic       dmem_we;
    dmem_addr_t dmem_addr;
    word_t      dmem_data;
    commit_t    commit;

    pito_core #(.num_harts(num_harts)) i_dut (
        .clk          (clk),
        .pito_io_rst_n(pito_io_rst_n),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .prog_en      (prog_en),
        .dmem_we      (dmem_we),
        .dmem_addr    (dmem_addr),
        .dmem_data    (dmem_data),
        .commit       (commit)
    );

    // ==================================================================
    // reference state
    // ==================================================================
    instr_t      prog [num_harts][prog_len];
    word_t       mreg [num_harts][32];
    word_t       mdmem [dmem_words];
    pc_t         mpc [num_harts];
    logic        halted [num_harts];
    logic [36:0] expq [num_harts][$];
    int          errors;
    int          checks;
    int          cyc;
    int          seed;
    string       phase;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // cycles since reset release
    always @(posedge clk) begin
        if (!pito_io_rst_n) cyc <= 0;
        else cyc <= cyc + 1;
    end

    initial begin
        #(timeout_ns * 1ns);
        $display("timeout, commits still outstanding");
        $display("TEST FAILED");
        $finish;
    end

    // rv32 encoders
    function automatic instr_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                     input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic instr_t enc_i(input int imm, input int rs1, input logic [2:0] f3,
                                     input int rd, input logic [6:0] opc);
        logic [11:0] i;
        i = 12'(imm);
        return {i, 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic instr_t enc_s(input int imm, input int rs2, input int rs1);
        logic [11:0] i;
        i = 12'(imm);
        return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], 7'b0100011};
    endfunction

    function automatic instr_t enc_b(input int imm, input int rs2, input int rs1,
                                     input logic [2:0] f3);
        logic [12:0] i;
        i = 13'(imm);
        return {i[12], i[10:5], 5'(rs2), 5'(rs1), f3, i[4:1], i[11], 7'b1100011};
    endfunction

    function automatic instr_t enc_j(input int imm, input int rd);
        logic [20:0] i;
        i = 21'(imm);
        return {i[20], i[10:1], i[11], i[19:12], 5'(rd), 7'b1101111};
    endfunction

    // ==================================================================
    // programs
    // ==================================================================
    task automatic build_programs();
        for (int h = 0; h < num_harts; h++) begin
            // same registers in every hart, values differ per hart
            prog[h][0]  = enc_i(100 + h, 0, 3'b000, 1, 7'b0010011);
            prog[h][1]  = {20'habc00 + 20'(h), 5'd2, 7'b0110111};
            prog[h][2]  = enc_r(7'h00, 2, 1, 3'b000, 3);
            prog[h][3]  = enc_r(7'h20, 1, 3, 3'b000, 4);
            prog[h][4]  = enc_r(7'h00, 1, 3, 3'b100, 5);
            prog[h][5]  = enc_r(7'h00, 2, 1, 3'b110, 6);
            prog[h][6]  = enc_r(7'h00, 2, 3, 3'b111, 7);
            prog[h][7]  = enc_i(4 * h, 0, 3'b010, 8, 7'b0000011);
            prog[h][8]  = enc_s(64 + 4 * h, 3, 0);
            // neighbour's stored word
            prog[h][9]  = enc_i(64 + 4 * ((h + 1) % num_harts), 0, 3'b010, 9, 7'b0000011);
            prog[h][10] = enc_b(8, 1, 1, 3'b000);
            prog[h][11] = enc_i(1, 0, 3'b000, 10, 7'b0010011);
            prog[h][12] = enc_b(8, 1, 1, 3'b001);
            prog[h][13] = enc_i(7, 0, 3'b000, 11, 7'b0010011);
            prog[h][14] = enc_b(8, 2, 1, 3'b001);
            prog[h][15] = enc_i(9, 0, 3'b000, 12, 7'b0010011);
            prog[h][16] = enc_j(8, 13);
            prog[h][17] = enc_i(3, 0, 3'b000, 14, 7'b0010011);
            prog[h][18] = enc_r(7'h00, 0, 1, 3'b000, 15);
            prog[h][19] = enc_i(5, 0, 3'b000, 0, 7'b0010011);
            // parks the hart, branches never commit
            prog[h][20] = enc_b(0, 0, 0, 3'b000);
        end
    endtask

    // one instruction of hart h by the rv32 rules
    task automatic model_step(input int h);
        instr_t ins;
        word_t  a, b, val, imm_i, imm_s, imm_b, imm_j;
        pc_t    nxt;
        logic   wr;
        int     rd;
        ins   = prog[h][(mpc[h] - pc_t'(h * 256)) >> 2];
        a     = mreg[h][ins[19:15]];
        b     = mreg[h][ins[24:20]];
        rd    = int'(ins[11:7]);
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        nxt   = mpc[h] + 4;
        wr    = 1'b0;
        val   = '0;
        if (ins == enc_b(0, 0, 0, 3'b000)) begin
            halted[h] = 1'b1;
            return;
        end
        case (ins[6:0])
            7'h33: begin
                wr = 1'b1;
                case (ins[14:12])
                    3'b000:  val = ins[30] ? a - b : a + b;
                    3'b100:  val = a ^ b;
                    3'b110:  val = a | b;
                    default: val = a & b;
                endcase
            end
            7'h13: begin
                wr  = 1'b1;
                val = a + imm_i;
            end
            7'h37: begin
                wr  = 1'b1;
                val = {ins[31:12], 12'b0};
            end
            7'h03: begin
                wr  = 1'b1;
                val = mdmem[8'((a + imm_i) >> 2)];
            end
            7'h23: mdmem[8'((a + imm_s) >> 2)] = b;
            7'h63: if ((ins[14:12] == 3'b000) == (a == b)) nxt = mpc[h] + imm_b;
            default: begin
                wr  = 1'b1;
                val = mpc[h] + 4;
                nxt = mpc[h] + imm_j;
            end
        endcase
        if (wr) begin
            if (rd != 0) mreg[h][rd] = val;
            expq[h].push_back({5'(rd), (rd == 0) ? 32'd0 : val});
        end
        mpc[h] = nxt;
    endtask

    // harts interleave in issue order, so stores are seen as in the core
    task automatic run_model();
        logic busy;
        for (int h = 0; h < num_harts; h++) begin
            mpc[h]    = pc_t'(h * 256);
            halted[h] = 1'b0;
        end
        busy = 1'b1;
        while (busy) begin
            busy = 1'b0;
            for (int h = 0; h < num_harts; h++) begin
                if (!halted[h]) model_step(h);
                if (!halted[h]) busy = 1'b1;
            end
        end
    endtask

    function automatic string group_name(input logic [4:0] rd);
        if (rd inside {[1:7]}) return "alu";
        if (rd inside {8, 9}) return "memory";
        if (rd inside {11, 13}) return "control";
        if (rd == 15) return "isolation";
        return "x0";
    endfunction

    task automatic check_val(input string name, input word_t exp, input word_t act);
        checks++;
        assert (exp === act) else begin
            $display("error %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // ==================================================================
    // commit checks
    // ==================================================================
    always @(negedge clk) begin
        logic [36:0] e;
        int          h;
        if (pito_io_rst_n && commit.valid) begin
            h = int'(commit.hart);
            check_val({phase, "/timing"}, word_t'((cyc - pipe_depth - 1) % num_harts),
                      word_t'(h));
            assert (expq[h].size() > 0) else begin
                $display("unexpected commit from hart %0d rd %0d", h, commit.rd);
                errors++;
            end
            if (expq[h].size() > 0) begin
                e = expq[h].pop_front();
                check_val({phase, "/", group_name(e[36:32]), "/rd"},
                          word_t'(e[36:32]), word_t'(commit.rd));
                check_val({phase, "/", group_name(e[36:32]), "/data"},
                          e[31:0], commit.data);
            end
        end
    end

    function automatic int pending();
        int n;
        n = 0;
        for (int h = 0; h < num_harts; h++) n += expq[h].size();
        return n;
    endfunction

    task automatic wait_done();
        while (pending() > 0) @(negedge clk);
        // quiet tail catches commits of skipped words
        repeat (2 * num_harts) @(negedge clk);
    endtask

    initial begin
        pito_io_rst_n = 1'b0;
        imem_we       = 1'b0;
        imem_addr     = '0;
        imem_data     = '0;
        prog_en       = 1'b0;
        dmem_we       = 1'b0;
        dmem_addr     = '0;
        dmem_data     = '0;
        errors        = 0;
        checks        = 0;
        seed          = 66;
        phase         = "run";
        for (int h = 0; h < num_harts; h++) begin
            for (int r = 0; r < 32; r++) mreg[h][r] = '0;
        end
        build_programs();
        @(negedge clk);
        for (int h = 0; h < num_harts; h++) begin
            for (int i = 0; i < prog_len; i++) begin
                imem_we   = 1'b1;
                imem_addr = imem_addr_t'(h * hart_span_words + i);
                imem_data = prog[h][i];
                @(negedge clk);
            end
        end
        imem_we = 1'b0;
        prog_en = 1'b1;
        for (int w = 0; w < num_harts; w++) begin
            dmem_we   = 1'b1;
            dmem_addr = dmem_addr_t'(w);
            dmem_data = $random(seed);
            mdmem[w]  = dmem_data;
            @(negedge clk);
        end
        dmem_we = 1'b0;
        prog_en = 1'b0;
        run_model();
        repeat (4) @(negedge clk);
        pito_io_rst_n = 1'b1;
        wait_done();

        // mid-run reset, code and data stay loaded
        phase         = "reset";
        pito_io_rst_n = 1'b0;
        run_model();
        repeat (4) @(negedge clk);
        pito_io_rst_n = 1'b1;
        wait_done();

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
rtl/pito_pkg.sv
rtl/pito_hart_ctrl.sv
rtl/pito_imem.sv
rtl/pito_decoder.sv
rtl/pito_regfile.sv
rtl/pito_execute.sv
rtl/pito_mem_stage.sv
rtl/pito_core.sv
testbench/pito_core_props.sv
testbench/pito_core_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module pito_core_tb -o sim
	./obj_dir/sim | tee /dev/stderr | grep -q "TEST OK"

clean:
	rm -rf obj_dir
